// File: verilog/rvSlicePkg.sv
`default_nettype none

package rvSlicePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic data types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one architectural data word.
    typedef logic [31:0] wordT;

    // index into the 32-entry register file.
    typedef logic [4:0] regAddrT;

    // major opcodes recognised by the decoder.
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;

    // alu operations.
    // passB forwards the second operand unchanged, used by lui.
    typedef enum logic [3:0] {
        AluAdd   = 4'd0,
        AluSub   = 4'd1,
        AluAnd   = 4'd2,
        AluOr    = 4'd3,
        AluXor   = 4'd4,
        AluSll   = 4'd5,
        AluSrl   = 4'd6,
        AluSra   = 4'd7,
        AluSlt   = 4'd8,
        AluSltu  = 4'd9,
        AluPassB = 4'd10
    } aluOpT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage structs.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // decoded instruction, 54 bits.
    // writesRd is already cleared for x0 and non-writing opcodes.
    typedef struct packed {
        logic    valid;
        aluOpT   aluOp;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
        logic    writesRd;
        logic    useImm;
        wordT    imm;
    } decodedT;

    // retired result, 39 bits.
    // doubles as the register file write port.
    typedef struct packed {
        logic    valid;
        logic    wen;
        regAddrT rd;
        wordT    data;
    } retireT;

endpackage

`default_nettype wire

// File: verilog/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  logic               clk,
    input  logic               rst,
    input  logic               inValid,
    input  rvSlicePkg::wordT   instr,
    output rvSlicePkg::decodedT dec
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction fields.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                altBit;
    rvSlicePkg::regAddrT rdField;
    rvSlicePkg::wordT    iImm;
    rvSlicePkg::wordT    uImm;
    logic                isWriter;
    rvSlicePkg::decodedT nextDec;

    assign opcode  = instr[6:0];
    assign rdField = instr[11:7];
    assign funct3  = instr[14:12];

    // funct7 bit 5 selects sub and sra.
    assign altBit = instr[30];

    // sign-extended i immediate.
    assign iImm = {{20{instr[31]}}, instr[31:20]};

    // u immediate already shifted into the upper 20 bits.
    assign uImm = {instr[31:12], 12'b0};

    // only these opcodes update the register file.
    assign isWriter = (opcode == rvSlicePkg::OpImm)
                   || (opcode == rvSlicePkg::OpReg)
                   || (opcode == rvSlicePkg::OpLui);

    // maps funct3 to an alu operation.
    // alt picks sub over add and sra over srl.
    function automatic rvSlicePkg::aluOpT aluFromFunct(
        input logic [2:0] f3,
        input logic       alt
    );
        rvSlicePkg::aluOpT op;
        case (f3)
            3'b000:  op = alt ? rvSlicePkg::AluSub : rvSlicePkg::AluAdd;
            3'b001:  op = rvSlicePkg::AluSll;
            3'b010:  op = rvSlicePkg::AluSlt;
            3'b011:  op = rvSlicePkg::AluSltu;
            3'b100:  op = rvSlicePkg::AluXor;
            3'b101:  op = alt ? rvSlicePkg::AluSra : rvSlicePkg::AluSrl;
            3'b110:  op = rvSlicePkg::AluOr;
            default: op = rvSlicePkg::AluAnd;
        endcase
        return op;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        // register fields pass straight through.
        nextDec.valid    = inValid;
        nextDec.rs1      = instr[19:15];
        nextDec.rs2      = instr[24:20];
        nextDec.rd       = rdField;
        // x0 is never written, so later stages skip the zero check.
        nextDec.writesRd = inValid && isWriter && (rdField != '0);
        nextDec.aluOp    = rvSlicePkg::AluAdd;
        nextDec.useImm   = 1'b0;
        nextDec.imm      = iImm;

        case (opcode)
            rvSlicePkg::OpReg:
            begin
                nextDec.aluOp = aluFromFunct(funct3, altBit);
            end
            rvSlicePkg::OpImm:
            begin
                // addi has no subtract form.
                nextDec.aluOp  = aluFromFunct(funct3, altBit && (funct3 == 3'b101));
                nextDec.useImm = 1'b1;
            end
            rvSlicePkg::OpLui:
            begin
                nextDec.aluOp  = rvSlicePkg::AluPassB;
                nextDec.useImm = 1'b1;
                nextDec.imm    = uImm;
            end
            default:
            begin
                // stores, branches and unknown opcodes retire quietly.
                nextDec.aluOp = rvSlicePkg::AluAdd;
            end
        endcase
    end

    // decoded instruction register, edge E.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            dec <= '0;
        end
        else
        begin
            dec <= nextDec;
        end
    end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  rvSlicePkg::decodedT dec,
    input  rvSlicePkg::retireT  wb,
    output rvSlicePkg::wordT    rdData1,
    output rvSlicePkg::wordT    rdData2,
    output rvSlicePkg::decodedT opDec
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 32 architectural registers.
    // entry 0 is cleared at reset and never written.
    rvSlicePkg::wordT regs [32];

    // write enable for the current writeback.
    logic writeHit;

    assign writeHit = wb.valid && wb.wen;

    // one read port.
    // x0 reads as zero, a same-edge write is bypassed in.
    function automatic rvSlicePkg::wordT readPort(
        input rvSlicePkg::regAddrT addr
    );
        rvSlicePkg::wordT value;
        if (addr == '0)
        begin
            value = '0;
        end
        else if (writeHit && (wb.rd == addr))
        begin
            // write-first, the new value wins.
            value = wb.data;
        end
        else
        begin
            value = regs[addr];
        end
        return value;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // commits on the edge after wb is presented.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeHit)
        begin
            // decoder never sets wen for rd zero.
            regs[wb.rd] <= wb.data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read ports.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // operands and the decoded instruction move together, edge E+1.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rdData1 <= '0;
            rdData2 <= '0;
            opDec   <= '0;
        end
        else
        begin
            rdData1 <= readPort(dec.rs1);
            rdData2 <= readPort(dec.rs2);
            opDec   <= dec;
        end
    end

endmodule

`default_nettype wire

// File: verilog/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute (
    input  logic                clk,
    input  logic                rst,
    input  rvSlicePkg::decodedT opDec,
    input  rvSlicePkg::wordT    rdData1,
    input  rvSlicePkg::wordT    rdData2,
    output rvSlicePkg::retireT  wb
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand selection.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    rvSlicePkg::wordT opA;
    rvSlicePkg::wordT rs2Val;
    rvSlicePkg::wordT opB;
    rvSlicePkg::wordT result;
    logic             fwdA;
    logic             fwdB;
    logic [4:0]       shamt;

    // previous result targets a source.
    // the instruction before this one has not reached the register file yet.
    assign fwdA = wb.valid && wb.wen && (wb.rd == opDec.rs1);
    assign fwdB = wb.valid && wb.wen && (wb.rd == opDec.rs2);

    assign opA    = fwdA ? wb.data : rdData1;
    assign rs2Val = fwdB ? wb.data : rdData2;

    // immediate forms replace the second operand.
    assign opB = opDec.useImm ? opDec.imm : rs2Val;

    // shift amount is the low five bits, also for the immediate forms.
    assign shamt = opB[4:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        case (opDec.aluOp)
            rvSlicePkg::AluAdd:
                result = opA + opB;
            rvSlicePkg::AluSub:
                result = opA - opB;
            rvSlicePkg::AluAnd:
                result = opA & opB;
            rvSlicePkg::AluOr:
                result = opA | opB;
            rvSlicePkg::AluXor:
                result = opA ^ opB;
            rvSlicePkg::AluSll:
                result = opA << shamt;
            rvSlicePkg::AluSrl:
                result = opA >> shamt;
            rvSlicePkg::AluSra:
                // arithmetic shift keeps the sign bit.
                result = rvSlicePkg::wordT'($signed(opA) >>> shamt);
            rvSlicePkg::AluSlt:
                result = {31'b0, $signed(opA) < $signed(opB)};
            rvSlicePkg::AluSltu:
                result = {31'b0, opA < opB};
            rvSlicePkg::AluPassB:
                // lui.
                result = opB;
            default:
                result = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // edge E+2, feeds both the retire output and the write port.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wb <= '0;
        end
        else
        begin
            wb.valid <= opDec.valid;
            wb.wen   <= opDec.writesRd;
            // rd is the raw field, also for stores and branches.
            wb.rd    <= opDec.rd;
            // non-writing instructions retire with zero data.
            wb.data  <= opDec.writesRd ? result : '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rvSliceTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvSliceTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               inValid,
    input  rvSlicePkg::wordT   instr,
    output rvSlicePkg::retireT retire
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline nets.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // decoder output.
    rvSlicePkg::decodedT dec;

    // register file outputs, one cycle behind dec.
    rvSlicePkg::decodedT opDec;
    rvSlicePkg::wordT    rdData1;
    rvSlicePkg::wordT    rdData2;

    // writeback, looped back into the register file.
    rvSlicePkg::retireT  wb;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stages.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    instrDecode decode_i (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .instr   (instr),
        .dec     (dec)
    );

    regFile regFile_i (
        .clk     (clk),
        .rst     (rst),
        .dec     (dec),
        .wb      (wb),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .opDec   (opDec)
    );

    aluExecute execute_i (
        .clk     (clk),
        .rst     (rst),
        .opDec   (opDec),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .wb      (wb)
    );

    // three clocks after inValid.
    assign retire = wb;

endmodule

`default_nettype wire

// File: dv/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int PeriodNs = 8
) (
    output logic clk
);

    // free-running clock, low at time zero.
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PeriodNs / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: dv/rvSlice_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rvSlice_asserts (
    input logic                clk,
    input logic                rst,
    input rvSlicePkg::retireT  wb,
    input rvSlicePkg::wordT    x0Value,
    input rvSlicePkg::wordT    rdData1,
    input rvSlicePkg::wordT    rdData2,
    input rvSlicePkg::decodedT opDec
);

    // number of assertion failures so far.
    int failures = 0;

    // x0 storage never leaves zero.
    assert property (@(posedge clk) disable iff (!rst) x0Value == '0)
    else
    begin
        failures++;
        $error("x0 holds a non-zero value");
    end

    // a register write needs a valid writeback.
    assert property (@(posedge clk) disable iff (!rst) wb.wen |-> wb.valid)
    else
    begin
        failures++;
        $error("register write without a valid writeback");
    end

    // read data and stage control are known once out of reset.
    assert property (@(posedge clk) disable iff (!rst)
        !$isunknown({rdData1, rdData2, opDec.valid, wb.valid, wb.wen}))
    else
    begin
        failures++;
        $error("unknown value on a register file port");
    end

endmodule

bind regFile rvSlice_asserts asserts_i (
    .clk     (clk),
    .rst     (rst),
    .wb      (wb),
    .x0Value (regs[0]),
    .rdData1 (rdData1),
    .rdData2 (rdData2),
    .opDec   (opDec)
);

`default_nettype wire

// File: dv/rvSliceTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvSliceTb;

    localparam int NumRandom   = 300;
    // directed instructions plus their idle cycles.
    localparam int MaxDirected = 80;
    // random part may add one idle cycle per instruction.
    localparam int WatchdogNs  = (MaxDirected + 2 * NumRandom + 20) * 8;

    logic               clk;
    logic               rst;
    logic               inValid;
    rvSlicePkg::wordT   instr;
    rvSlicePkg::retireT retire;

    // architectural model and outstanding expectations.
    rvSlicePkg::wordT   modelRegs [32];
    rvSlicePkg::retireT expQ [$];
    int                 cycQ [$];
    rvSlicePkg::retireT expRet;
    int                 expCyc;
    int                 cyc = 0;
    int                 seed;
    int                 errors = 0;
    int                 checks = 0;

    tbClock #(.PeriodNs(8)) clock_i (.clk(clk));

    rvSliceTop dut_i (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .instr   (instr),
        .retire  (retire)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encoders and reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // r layout, also used for stores and branches.
    function automatic rvSlicePkg::wordT encodeR(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic rvSlicePkg::wordT encodeI(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rvSlicePkg::OpImm};
    endfunction

    function automatic rvSlicePkg::wordT encodeLui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rvSlicePkg::OpLui};
    endfunction

    // executes one instruction in program order, returns what must retire.
    function automatic rvSlicePkg::retireT refExecute(input rvSlicePkg::wordT ins);
        rvSlicePkg::retireT r;
        logic [6:0]         opc;
        logic [4:0]         rdIdx;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        res;
        logic               writes;
        opc   = ins[6:0];
        rdIdx = ins[11:7];
        a     = modelRegs[ins[19:15]];
        // register form reads rs2, immediate form sign-extends bits 31:20.
        b = (opc == rvSlicePkg::OpReg) ? modelRegs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        case (ins[14:12])
            3'd0:    res = (opc == rvSlicePkg::OpReg && ins[30]) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = {31'b0, $signed(a) < $signed(b)};
            3'd3:    res = {31'b0, a < b};
            3'd4:    res = a ^ b;
            3'd5:    res = ins[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        res    = (opc == rvSlicePkg::OpLui) ? {ins[31:12], 12'b0} : res;
        writes = (opc == rvSlicePkg::OpReg || opc == rvSlicePkg::OpImm
               || opc == rvSlicePkg::OpLui) && (rdIdx != 5'd0);
        modelRegs[rdIdx] = writes ? res : modelRegs[rdIdx];
        r.valid = 1'b1;
        r.wen   = writes;
        r.rd    = rdIdx;
        r.data  = writes ? res : 32'd0;
        return r;
    endfunction

    // legal encodings over x0..x7 so hazards stay frequent.
    function automatic rvSlicePkg::wordT randomInstr();
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r   = $random(seed);
        s   = $random(seed);
        f3  = r[6:4];
        f7  = (r[7] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        imm = s[11:0];
        // shift immediates carry funct7 in the upper bits.
        if (f3 == 3'd1 || f3 == 3'd5)
            imm[11:5] = (f3 == 3'd5) ? f7 : 7'h00;
        if (r[3:0] < 4'd6)
            return encodeR(f7, {2'b0, r[16:14]}, {2'b0, r[13:11]}, f3, {2'b0, r[10:8]},
                           rvSlicePkg::OpReg);
        else if (r[3:0] < 4'd12)
            return encodeI(imm, {2'b0, r[13:11]}, f3, {2'b0, r[10:8]});
        else if (r[3:0] < 4'd14)
            return encodeLui(s[31:12], {2'b0, r[10:8]});
        else
            return encodeR(s[31:25], {2'b0, r[16:14]}, {2'b0, r[13:11]}, f3, {2'b0, r[10:8]},
                           r[0] ? rvSlicePkg::OpBranch : rvSlicePkg::OpStore);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // retire is due three edges after the one that captures ins.
    task automatic issue(input rvSlicePkg::wordT ins);
        @(negedge clk);
        inValid = 1'b1;
        instr   = ins;
        expQ.push_back(refExecute(ins));
        cycQ.push_back(cyc + 3);
    endtask

    task automatic idle();
        @(negedge clk);
        inValid = 1'b0;
    endtask

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    initial
    begin
        seed    = 32'h1748;
        rst     = 1'b0;
        inValid = 1'b0;
        instr   = '0;
        for (int i = 0; i < 32; i++)
        begin
            modelRegs[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        // nothing may retire while idle.
        repeat (4) idle();
        // known values, x4 forwards from the lui right before it.
        issue(encodeLui(20'h80000, 5'd1));
        issue(encodeI(12'hFFF, 5'd0, 3'd0, 5'd2));
        issue(encodeI(12'h005, 5'd0, 3'd0, 5'd3));
        issue(encodeLui(20'h12345, 5'd4));
        issue(encodeI(12'h678, 5'd4, 3'd0, 5'd4));
        repeat (3) idle();
        // every register and immediate operation, including the signed cases.
        for (int f3 = 0; f3 < 8; f3++)
        begin
            issue(encodeR(7'h00, 5'd4, 5'd1, 3'(f3), 5'(5 + f3), rvSlicePkg::OpReg));
        end
        issue(encodeR(7'h20, 5'd4, 5'd1, 3'd0, 5'd13, rvSlicePkg::OpReg));
        issue(encodeR(7'h20, 5'd4, 5'd1, 3'd5, 5'd14, rvSlicePkg::OpReg));
        issue(encodeR(7'h00, 5'd3, 5'd2, 3'd2, 5'd15, rvSlicePkg::OpReg));
        issue(encodeR(7'h00, 5'd3, 5'd2, 3'd3, 5'd16, rvSlicePkg::OpReg));
        for (int f3 = 0; f3 < 8; f3++)
        begin
            issue(encodeI((f3 == 1 || f3 == 5) ? 12'd3 : 12'h8F0, 5'd1, 3'(f3), 5'(5 + f3)));
        end
        issue(encodeI(12'h403, 5'd1, 3'd5, 5'd14));
        // dependent pairs at distance 1, 2 and 3.
        for (int d = 1; d <= 3; d++)
        begin
            issue(encodeI(12'(d * 11), 5'd0, 3'd0, 5'd20));
            for (int k = 1; k < d; k++)
            begin
                issue(encodeI(12'h001, 5'd3, 3'd0, 5'd21));
            end
            issue(encodeR(7'h00, 5'd20, 5'd20, 3'd0, 5'd22, rvSlicePkg::OpReg));
            issue(encodeR(7'h20, 5'd22, 5'd20, 3'd0, 5'd20, rvSlicePkg::OpReg));
        end
        repeat (5) issue(encodeI(12'h001, 5'd23, 3'd0, 5'd23));
        // x0 target, then stores, branches and an unknown opcode.
        issue(encodeI(12'h009, 5'd3, 3'd0, 5'd0));
        issue(encodeR(7'h00, 5'd3, 5'd0, 3'd0, 5'd24, rvSlicePkg::OpReg));
        issue(encodeR(7'h01, 5'd3, 5'd1, 3'd2, 5'd7, rvSlicePkg::OpStore));
        issue(encodeR(7'h00, 5'd3, 5'd1, 3'd0, 5'd9, rvSlicePkg::OpBranch));
        issue(encodeR(7'h00, 5'd3, 5'd1, 3'd0, 5'd10, 7'b0000000));
        issue(encodeR(7'h00, 5'd0, 5'd7, 3'd0, 5'd25, rvSlicePkg::OpReg));
        repeat (3) idle();
        for (int n = 0; n < NumRandom; n++)
        begin
            if (($random(seed) & 7) == 0)
                idle();
            issue(randomInstr());
        end
        idle();
        while (expQ.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
        // concurrent assertion failures in the register file count too.
        errors += dut_i.regFile_i.asserts_i.failures;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking and watchdog.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // retire only moves on rising edges, so it is stable here.
    always @(negedge clk)
    begin
        if (rst && retire.valid && expQ.size() == 0)
        begin
            errors++;
            $display("a retire appeared at %0t with no instruction outstanding", $time);
        end
        else if (rst && retire.valid)
        begin
            expRet = expQ.pop_front();
            expCyc = cycQ.pop_front();
            checks++;
            assert (retire == expRet)
            else
            begin
                errors++;
                $display("[FAIL] %0t retire %h, expected %h", $time, retire, expRet);
            end
            assert (cyc == expCyc)
            else
            begin
                errors++;
                $display("[FAIL] %0t retire in cycle %0d, expected %0d", $time, cyc, expCyc);
            end
        end
        else if (rst)
        begin
            assert (!retire.wen)
            else
            begin
                errors++;
                $display("[FAIL] %0t wen set without retire.valid", $time);
            end
        end
    end

    initial
    begin
        #(WatchdogNs);
        $display("watchdog expired with %0d retires still outstanding", expQ.size());
        $display("checks %0d, errors %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/rvSlicePkg.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/aluExecute.sv
verilog/rvSliceTop.sv
dv/tbClock.sv
dv/rvSlice_asserts.sv
dv/rvSliceTb.sv

// File: Makefile
TOP := rvSliceTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
